/* source/pad_pkg.sv */
// pixel type, bank state enum and column sequencer state enum
package pad_pkg;

  typedef logic [7:0] pix_t;  // one camera pixel

  // life cycle of one ping-pong bank
  typedef enum logic [1:0] {
    FREE    = 2'd0,
    FILLING = 2'd1,
    FULL    = 2'd2,
    READING = 2'd3
  } bank_state_e;

  // pad_column_gen sequencer
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LEFT_PAD  = 3'd1,  // all-pad column 0
    FETCH     = 3'd2,  // reading down one image column
    PUSH      = 3'd3,  // wrap and send the fetched column
    RIGHT_PAD = 3'd4   // all-pad last column
  } gen_state_e;

endpackage

/* source/buf_rd_if.sv */
// bank read port and bank credit return between frame store and column sequencer
interface buf_rd_if import pad_pkg::*; #(
  parameter int IMG_H = 24,
  parameter int IMG_W = 32
);

  localparam int AW = $clog2(IMG_H * IMG_W);

  logic [1:0]    full_mask;  // one bit per bank, full or being read
  logic          rd_en;
  logic          rd_bank;
  logic [AW-1:0] rd_addr;    // row * IMG_W + column
  pix_t          rd_data;    // one cycle after rd_en
  logic          rel;        // bank release pulse
  logic          rel_bank;

  modport wr (
    output full_mask,
    output rd_data,
    input  rd_en,
    input  rd_bank,
    input  rd_addr,
    input  rel,
    input  rel_bank
  );

  modport rd (
    input  full_mask,
    input  rd_data,
    output rd_en,
    output rd_bank,
    output rd_addr,
    output rel,
    output rel_bank
  );

endinterface

/* source/col_if.sv */
// padded column transfer and queue slot credit return
interface col_if import pad_pkg::*; #(
  parameter int IMG_H = 24
);

  pix_t [0:IMG_H+1] data;    // element 0 is the top pixel, in the MSB
  logic             push;
  logic             last;    // final column of a frame
  logic             credit;  // one queue slot freed

  modport src (
    output push,
    output data,
    output last,
    input  credit
  );

  modport dst (
    input  push,
    input  data,
    input  last,
    output credit
  );

endinterface

/* source/frame_pingpong.sv */
// two-bank frame store with raster write addressing, bank states and overflow flag
module frame_pingpong import pad_pkg::*; #(
  parameter int IMG_H = 24,
  parameter int IMG_W = 32
) (
  input  logic dout_clk,
  input  logic rst_n,
  input  pix_t i_pix,
  input  logic i_pix_vld,
  output logic o_overflow,
  buf_rd_if.wr rd
);

  localparam int NPIX = IMG_H * IMG_W;
  localparam int AW   = $clog2(NPIX);

  pix_t          mem [2][NPIX];  // ping-pong banks
  bank_state_e   bank_st [2];
  logic [AW-1:0] wr_addr;        // raster position within the frame
  logic          wr_bank;        // bank last written
  logic          tgt_bank;
  logic          tgt_ok;
  logic          wr_en;
  logic          overflow_q;

  // stay on the filling bank, otherwise claim the lower free one
  always_comb begin
    tgt_bank = wr_bank;
    tgt_ok   = 1'b0;
    if (bank_st[wr_bank] == FILLING) begin
      tgt_ok = 1'b1;
    end else if (bank_st[0] == FREE) begin
      tgt_bank = 1'b0;
      tgt_ok   = 1'b1;
    end else if (bank_st[1] == FREE) begin
      tgt_bank = 1'b1;
      tgt_ok   = 1'b1;
    end
  end

  assign wr_en = i_pix_vld && tgt_ok;

  always_ff @(posedge dout_clk or negedge rst_n) begin
    if (!rst_n) begin
      bank_st[0] <= FREE;
      bank_st[1] <= FREE;
      wr_bank    <= 1'b0;
      wr_addr    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_bank <= tgt_bank;
        if (wr_addr == AW'(NPIX - 1)) begin
          wr_addr           <= '0;
          bank_st[tgt_bank] <= FULL;  // frame complete
        end else begin
          wr_addr           <= wr_addr + 1'b1;
          bank_st[tgt_bank] <= FILLING;
        end
      end
      if (i_pix_vld && !tgt_ok) begin
        overflow_q <= 1'b1;  // sticky until reset
      end
      if (rd.rd_en && bank_st[rd.rd_bank] == FULL) begin
        bank_st[rd.rd_bank] <= READING;  // first read of the bank
      end
      if (rd.rel) begin
        bank_st[rd.rel_bank] <= FREE;  // credit back to the write side
      end
    end
  end

  always_ff @(posedge dout_clk) begin
    if (wr_en) begin
      mem[tgt_bank][wr_addr] <= i_pix;
    end
    if (rd.rd_en) begin
      rd.rd_data <= mem[rd.rd_bank][rd.rd_addr];
    end
  end

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      rd.full_mask[b] = (bank_st[b] == FULL) || (bank_st[b] == READING);
    end
  end

  assign o_overflow = overflow_q;

endmodule

/* source/pad_column_gen.sv */
// column sequencer with bank pick, column reads, pad wrapping and slot credit tracking
module pad_column_gen import pad_pkg::*; #(
  parameter int IMG_H = 24,
  parameter int IMG_W = 32
) (
  input  logic dout_clk,
  input  logic rst_n,
  input  pix_t i_pad_value,
  buf_rd_if.rd rd,
  col_if.src   col
);

  localparam int AW = $clog2(IMG_H * IMG_W);
  localparam int RW = $clog2(IMG_H);
  localparam int CW = $clog2(IMG_W);

  gen_state_e       state;
  logic             cur_bank;   // bank being read
  pix_t             pad_q;      // pad value for the current frame
  logic [RW-1:0]    row_cnt;    // read row within the column
  logic [CW-1:0]    col_cnt;    // image column
  logic [1:0]       slot_cred;  // free entries in column_out
  logic             rd_vld;     // rd_data holds a fresh pixel
  logic             rel_q;
  pix_t [0:IMG_H-2] col_buf;    // all but the bottom pixel
  logic             can_push;
  logic             last_read;

  assign can_push  = (slot_cred != 2'd0);
  assign last_read = (state == FETCH) && (row_cnt == RW'(IMG_H - 1)) &&
                     (col_cnt == CW'(IMG_W - 1));

  assign rd.rd_en    = (state == FETCH);
  assign rd.rd_bank  = cur_bank;
  assign rd.rd_addr  = AW'(row_cnt * IMG_W + col_cnt);  // walk down the column
  assign rd.rel      = rel_q;
  assign rd.rel_bank = cur_bank;

  assign col.push = can_push &&
                    (state == LEFT_PAD || state == PUSH || state == RIGHT_PAD);
  assign col.last = (state == RIGHT_PAD);

  // bottom pixel comes straight from the read register
  always_comb begin
    if (state == PUSH) begin
      col.data = {pad_q, col_buf, rd.rd_data, pad_q};
    end else begin
      col.data = {(IMG_H + 2){pad_q}};
    end
  end

  always_ff @(posedge dout_clk) begin
    if (state == IDLE && rd.full_mask != 2'b00) begin
      pad_q <= i_pad_value;  // once per frame
    end
    if (rd_vld && state == FETCH) begin
      col_buf <= {col_buf[1:IMG_H-2], rd.rd_data};  // shift up, top first
    end
  end

  always_ff @(posedge dout_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      cur_bank  <= 1'b0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      slot_cred <= 2'd2;
      rd_vld    <= 1'b0;
      rel_q     <= 1'b0;
    end else begin
      rd_vld    <= rd.rd_en;
      rel_q     <= last_read;  // bank done after the final read
      slot_cred <= slot_cred - {1'b0, col.push} + {1'b0, col.credit};
      case (state)
        IDLE: begin
          if (rd.full_mask != 2'b00) begin
            cur_bank <= ~rd.full_mask[0];  // lower bank wins
            col_cnt  <= '0;
            state    <= LEFT_PAD;
          end
        end
        LEFT_PAD: begin
          if (can_push) begin
            row_cnt <= '0;
            state   <= FETCH;
          end
        end
        FETCH: begin
          row_cnt <= row_cnt + 1'b1;
          if (row_cnt == RW'(IMG_H - 1)) begin
            state <= PUSH;
          end
        end
        PUSH: begin
          if (can_push) begin
            row_cnt <= '0;
            if (col_cnt == CW'(IMG_W - 1)) begin
              state <= RIGHT_PAD;
            end else begin
              col_cnt <= col_cnt + 1'b1;
              state   <= FETCH;
            end
          end
        end
        RIGHT_PAD: begin
          if (can_push) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

/* source/column_out.sv */
// two-entry column queue with downstream credit counter
module column_out import pad_pkg::*; #(
  parameter int IMG_H       = 24,
  parameter int OUT_CREDITS = 4
) (
  input  logic                   dout_clk,
  input  logic                   rst_n,
  col_if.dst                     col,
  input  logic                   i_col_credit,
  output logic [(IMG_H+2)*8-1:0] o_col_data,
  output logic                   o_col_vld,
  output logic                   o_col_last
);

  localparam int DW = $clog2(OUT_CREDITS + 1);

  pix_t [0:IMG_H+1] q_data [2];
  logic             q_last [2];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       q_cnt;    // 0 to 2 columns held
  logic [DW-1:0]    dn_cred;  // downstream credits left
  logic             pop;

  assign o_col_vld  = (q_cnt != 2'd0) && (dn_cred != '0);
  assign pop        = o_col_vld;
  assign o_col_data = q_data[rd_ptr];
  assign o_col_last = q_last[rd_ptr] && o_col_vld;
  assign col.credit = pop;  // slot freed

  always_ff @(posedge dout_clk) begin
    if (col.push) begin
      q_data[wr_ptr] <= col.data;
      q_last[wr_ptr] <= col.last;
    end
  end

  always_ff @(posedge dout_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      q_cnt   <= 2'd0;
      dn_cred <= DW'(OUT_CREDITS);
    end else begin
      if (col.push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      q_cnt   <= q_cnt + {1'b0, col.push} - {1'b0, pop};
      dn_cred <= dn_cred - DW'(pop) + DW'(i_col_credit);
    end
  end

endmodule

/* source/input_pad_top.sv */
// top level wiring frame store, column sequencer and column output stage
module input_pad_top import pad_pkg::*; #(
  parameter int IMG_H       = 24,
  parameter int IMG_W       = 32,
  parameter int OUT_CREDITS = 4
) (
  input  logic                   dout_clk,
  input  logic                   rst_n,
  input  pix_t                   i_pix,
  input  logic                   i_pix_vld,
  input  pix_t                   i_pad_value,
  input  logic                   i_col_credit,
  output logic [(IMG_H+2)*8-1:0] o_col_data,
  output logic                   o_col_vld,
  output logic                   o_col_last,
  output logic                   o_overflow
);

  buf_rd_if #(.IMG_H(IMG_H), .IMG_W(IMG_W)) buf_rd ();  // bank link
  col_if    #(.IMG_H(IMG_H))                col_lnk ();  // column link

  frame_pingpong #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_frame_pingpong (
    .dout_clk   (dout_clk),
    .rst_n      (rst_n),
    .i_pix      (i_pix),
    .i_pix_vld  (i_pix_vld),
    .o_overflow (o_overflow),
    .rd         (buf_rd.wr)
  );

  pad_column_gen #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_pad_column_gen (
    .dout_clk    (dout_clk),
    .rst_n       (rst_n),
    .i_pad_value (i_pad_value),
    .rd          (buf_rd.rd),
    .col         (col_lnk.src)
  );

  column_out #(.IMG_H(IMG_H), .OUT_CREDITS(OUT_CREDITS)) u_column_out (
    .dout_clk     (dout_clk),
    .rst_n        (rst_n),
    .col          (col_lnk.dst),
    .i_col_credit (i_col_credit),
    .o_col_data   (o_col_data),
    .o_col_vld    (o_col_vld),
    .o_col_last   (o_col_last)
  );

endmodule

/* bench/tb_clock_gen.sv */
// test clock source and reset generator with a re-reset request input
module tb_clock_gen (
  input  logic i_rst_req,
  output logic o_dout_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial o_dout_clk = 1'b0;
  always #2 o_dout_clk = ~o_dout_clk;  // 4 ns period

  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_dout_clk);
    #1 o_rst_n = 1'b1;
    forever begin
      @(posedge i_rst_req);
      o_rst_n = 1'b0;  // asynchronous assert, two cycles long
      repeat (2) @(posedge o_dout_clk);
      #1 o_rst_n = 1'b1;
    end
  end
endmodule

/* bench/tb_input_pad.sv */
// frame stimulus, padded column reference, output checker, credit model and watchdog
module tb_input_pad;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IMG_H        = 24;
  localparam int IMG_W        = 32;
  localparam int OUT_CREDITS  = 4;
  localparam int NPIX         = IMG_H * IMG_W;
  localparam int COLW         = (IMG_H + 2) * 8;
  localparam int FRAME_CYCLES = (IMG_H + 1) * (IMG_W + 2) * 3;
  localparam int NUM_FRAMES   = 11;  // frames driven over all tests
  localparam int TRICKLE_GAP  = 7;
  localparam int CRED_NOW     = 0;
  localparam int CRED_HOLD    = 1;
  localparam int CRED_TRICKLE = 2;

  typedef logic [NPIX*8-1:0] frame_t;  // pixel (r,c) at byte r*IMG_W+c

  logic            dout_clk;
  logic            rst_n;
  logic            rst_req = 1'b0;
  logic [7:0]      pix;
  logic            pix_vld;
  logic [7:0]      pad_value;
  logic            col_credit = 1'b0;
  logic [COLW-1:0] col_data;
  logic            col_vld;
  logic            col_last;
  logic            overflow;
  frame_t          frame_q[$];   // frames still expected at the output
  logic [7:0]      pad_q[$];
  logic [COLW-1:0] exp_col;
  logic            exp_last;
  logic            cred_next = 1'b0;
  int              col_idx = 0;
  int              frames_done = 0;
  int              compared = 0;
  int              errors = 0;
  int              tb_cred = OUT_CREDITS;  // downstream credits left
  int              credit_mode = CRED_NOW;
  int              tick = 0;

  tb_clock_gen clk_gen_i (
    .i_rst_req  (rst_req),
    .o_dout_clk (dout_clk),
    .o_rst_n    (rst_n)
  );

  input_pad_top dut_i (
    .dout_clk     (dout_clk),
    .rst_n        (rst_n),
    .i_pix        (pix),
    .i_pix_vld    (pix_vld),
    .i_pad_value  (pad_value),
    .i_col_credit (col_credit),
    .o_col_data   (col_data),
    .o_col_vld    (col_vld),
    .o_col_last   (col_last),
    .o_overflow   (overflow)
  );

  // expected column c of the padded image, element 0 in the top byte
  function automatic logic [COLW-1:0] padded_column(input frame_t frm, input int c,
                                                     input logic [7:0] pad);
    logic [COLW-1:0] col;
    for (int e = 0; e < IMG_H + 2; e++) begin
      if (c == 0 || c == IMG_W + 1 || e == 0 || e == IMG_H + 1) begin
        col[COLW-1-8*e -: 8] = pad;
      end else begin
        col[COLW-1-8*e -: 8] = frm[((e - 1) * IMG_W + c - 1) * 8 +: 8];
      end
    end
    return col;
  endfunction

  function automatic frame_t random_frame();
    frame_t f;
    for (int i = 0; i < NPIX; i++) begin
      f[i*8 +: 8] = 8'($urandom);
    end
    return f;
  endfunction

  task automatic send_frame(input frame_t f, input logic [7:0] pad, input bit expect_out,
                            input int n_pix);
    if (expect_out) begin
      frame_q.push_back(f);
      pad_q.push_back(pad);
    end
    for (int i = 0; i < n_pix; i++) begin
      @(posedge dout_clk);
      #1;
      pad_value = pad;
      pix       = f[i*8 +: 8];
      pix_vld   = 1'b1;
    end
    @(posedge dout_clk);
    #1;
    pix_vld = 1'b0;
  endtask

  task automatic wait_for_frames(input int n);
    int waited;
    int limit;
    waited = 0;
    limit  = (n - frames_done) * FRAME_CYCLES;
    while (frames_done < n && waited < limit) begin
      @(posedge dout_clk);
      waited++;
    end
    if (frames_done < n) begin
      $display("timed out waiting for frame %0d to leave the DUT", n);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge dout_clk);
    #1;
    rst_req = 1'b1;
    @(posedge dout_clk);
    #1;
    rst_req = 1'b0;
    if (col_vld !== 1'b0) begin
      $display("Error: o_col_vld in reset expected 0 actual %h", col_vld);
      errors++;
    end
    if (overflow !== 1'b0) begin
      $display("Error: o_overflow in reset expected 0 actual %h", overflow);
      errors++;
    end
    frame_q.delete();  // nothing stored survives reset
    pad_q.delete();
    wait (rst_n);
    @(posedge dout_clk);
  endtask

  // outputs and driven credits are stable at the falling edge
  always @(negedge dout_clk) begin
    if (!rst_n) begin
      tb_cred   = OUT_CREDITS;
      col_idx   = 0;
      cred_next = 1'b0;
    end else begin
      if (col_vld && tb_cred == 0) begin
        $display("column sent while the downstream credit count was zero");
        errors++;
      end
      tb_cred = tb_cred - int'(col_vld) + int'(col_credit);
      if (col_vld) begin
        if (frame_q.size() == 0) begin
          $display("column sent with no frame expected");
          errors++;
        end else begin
          exp_col  = padded_column(frame_q[0], col_idx, pad_q[0]);
          exp_last = (col_idx == IMG_W + 1);
          compared++;
          if (col_data !== exp_col) begin
            $display("Error: o_col_data col %0d expected %h actual %h", col_idx, exp_col,
                     col_data);
            errors++;
          end
          if (col_last !== exp_last) begin
            $display("Error: o_col_last col %0d expected %h actual %h", col_idx, exp_last,
                     col_last);
            errors++;
          end
          if (exp_last) begin
            frame_q.delete(0);
            pad_q.delete(0);
            col_idx = 0;
            frames_done++;
          end else begin
            col_idx++;
          end
        end
      end
      tick = (tick + 1) % TRICKLE_GAP;
      case (credit_mode)
        CRED_NOW:     cred_next = (tb_cred < OUT_CREDITS);
        CRED_TRICKLE: cred_next = (tb_cred < OUT_CREDITS) && (tick == 0);
        default:      cred_next = 1'b0;
      endcase
    end
  end

  always @(posedge dout_clk) begin
    #1;
    col_credit = cred_next;  // one credit per cycle at most
  end

  initial begin
    repeat (NUM_FRAMES * FRAME_CYCLES + 2000) @(posedge dout_clk);
    $display("watchdog expired before all tests finished");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [7:0] pad;
    int base;
    void'($urandom(32'hefeb4b31));
    pix       = '0;
    pix_vld   = 1'b0;
    pad_value = '0;
    wait (rst_n);
    @(posedge dout_clk);

    // one frame, credits back at once
    base = frames_done;
    send_frame(random_frame(), 8'($urandom), 1'b1, NPIX);
    wait_for_frames(base + 1);

    // three frames alternating banks, each with its own pad value
    base = frames_done;
    for (int k = 0; k < 3; k++) begin
      if (k >= 2) begin
        wait_for_frames(base + k - 1);  // keeps the next pad value off the pending pick
      end
      repeat (20) @(posedge dout_clk);
      send_frame(random_frame(), 8'(8'h2a + k * 8'h55), 1'b1, NPIX);
    end
    wait_for_frames(base + 3);

    // credits held back, then one every few cycles
    base        = frames_done;
    credit_mode = CRED_HOLD;
    send_frame(random_frame(), 8'($urandom), 1'b1, NPIX);
    repeat (200) @(posedge dout_clk);
    credit_mode = CRED_TRICKLE;
    wait_for_frames(base + 1);
    credit_mode = CRED_NOW;

    // back to back frames with the output stalled, third one dropped
    base        = frames_done;
    pad         = 8'($urandom);
    credit_mode = CRED_HOLD;
    for (int k = 0; k < 3; k++) begin
      send_frame(random_frame(), pad, k < 2, NPIX);
    end
    if (overflow !== 1'b1) begin
      $display("overflow flag never rose while both banks were held");
      errors++;
    end
    credit_mode = CRED_NOW;
    wait_for_frames(base + 2);

    // reset halfway through the second frame
    pad         = 8'($urandom);
    credit_mode = CRED_HOLD;  // queue stays full into the reset
    send_frame(random_frame(), pad, 1'b1, NPIX);
    send_frame(random_frame(), pad, 1'b0, NPIX / 2);
    apply_reset();
    credit_mode = CRED_NOW;
    base = frames_done;
    send_frame(random_frame(), pad, 1'b1, NPIX);
    wait_for_frames(base + 1);

    repeat (10) @(posedge dout_clk);
    $display("columns compared: %0d, errors: %0d", compared, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end
endmodule

/* vlog.f */
source/pad_pkg.sv
source/buf_rd_if.sv
source/col_if.sv
source/frame_pingpong.sv
source/pad_column_gen.sv
source/column_out.sv
source/input_pad_top.sv
bench/tb_clock_gen.sv
bench/tb_input_pad.sv

/* Makefile */
TOP = tb_input_pad

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -f vlog.f \
	  --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
